// ==== evbuf_pkg.sv ====
package evbuf_pkg;

    // free-slot pool
    localparam int NUM_SLOTS = 4;
    localparam int SLOT_W    = 2;

    // the chunk of this ident closes an event
    localparam int LAST_IDENT = 6;

    // address strides in bytes
    localparam int IDENT_BYTES = 16384;
    // 8 idents per slot
    localparam int SLOT_BYTES  = 131072;

    // up to 2048 words per chunk
    localparam int OFFS_W = 11;
    localparam int CNT_W  = 14;

    typedef logic [63:0]         payload_t;
    typedef logic [4:0]          ident_t;
    typedef logic [SLOT_W-1:0]   slot_t;
    typedef logic [OFFS_W-1:0]   offset_t;
    typedef logic [31:0]         addr_t;
    typedef logic [CNT_W-1:0]    wcount_t;

    // one accepted payload word with its placement in the event buffer
    typedef struct packed {
        payload_t payload;
        ident_t   ident;
        slot_t    slot;
        offset_t  offset;
        // last word of the event
        logic     ev_end;
    } tagged_word_t;

    // completion record handed to software
    typedef struct packed {
        slot_t   slot;
        wcount_t wcount;
    } cmpl_t;

endpackage

// ==== payload_decode.sv ====
`timescale 1ns/1ps

module payload_decode import evbuf_pkg::*; (
    input  logic         memclk,
    input  logic         rst_n_i,

    input  payload_t     payload_i,
    input  logic         payload_valid_i,
    input  logic         payload_last_i,
    input  ident_t       payload_ident_i,
    output logic         payload_has_space_o,
    output logic         overflow_o,

    input  logic         done_valid_i,
    input  slot_t        done_slot_i,

    output tagged_word_t tagged_o,
    output logic         tagged_valid_o
);

    // circular pool of free slots
    slot_t             pool_q [NUM_SLOTS];
    slot_t             rd_ptr_q;
    slot_t             wr_ptr_q;
    logic [SLOT_W:0]   fill_q;

    // open event state
    logic              ev_open_q;
    slot_t             cur_slot_q;
    offset_t           offset_q;

    logic              pool_avail;
    logic              accept;
    logic              pop;
    logic              ev_end;
    slot_t             word_slot;

    assign pool_avail = (fill_q != '0);

    // a word is only taken if it belongs to an open event or can start one
    assign accept = payload_valid_i && (ev_open_q || pool_avail);
    assign pop    = accept && !ev_open_q;
    assign ev_end = accept && payload_last_i && (payload_ident_i == ident_t'(LAST_IDENT));

    // first word of an event takes the slot at the head of the pool
    assign word_slot = ev_open_q ? cur_slot_q : pool_q[rd_ptr_q];

    assign payload_has_space_o = ev_open_q || pool_avail;

    // pool FIFO, reset hands out slots 0..NUM_SLOTS-1 in order
    always_ff @(posedge memclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                pool_q[i] <= slot_t'(i);
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            fill_q   <= (SLOT_W+1)'(NUM_SLOTS);
        end else begin
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (done_valid_i) begin
                pool_q[wr_ptr_q] <= done_slot_i;
                wr_ptr_q         <= wr_ptr_q + 1'b1;
            end
            case ({done_valid_i, pop})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;
            endcase
        end
    end

    // event and chunk tracking
    always_ff @(posedge memclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ev_open_q  <= 1'b0;
            cur_slot_q <= '0;
            offset_q   <= '0;
        end else if (accept) begin
            // a single-word event opens and closes on the same edge
            ev_open_q <= !ev_end;
            if (pop) begin
                cur_slot_q <= pool_q[rd_ptr_q];
            end
            // offset restarts at every chunk boundary
            if (payload_last_i) begin
                offset_q <= '0;
            end else begin
                offset_q <= offset_q + 1'b1;
            end
        end
    end

    // strobes out
    always_ff @(posedge memclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tagged_valid_o <= 1'b0;
            overflow_o     <= 1'b0;
        end else begin
            tagged_valid_o <= accept;
            overflow_o     <= payload_valid_i && !accept;
        end
    end

    // tagged word payload
    always_ff @(posedge memclk) begin
        if (accept) begin
            tagged_o.payload <= payload_i;
            tagged_o.ident   <= payload_ident_i;
            tagged_o.slot    <= word_slot;
            tagged_o.offset  <= offset_q;
            tagged_o.ev_end  <= ev_end;
        end
    end

endmodule

// ==== write_addr_gen.sv ====
`timescale 1ns/1ps

module write_addr_gen import evbuf_pkg::*; #(
    // buffer base in units of 4 kB
    parameter int unsigned BASE_ADDR_4KB = 4
) (
    input  logic         memclk,
    input  logic         rst_n_i,

    input  tagged_word_t tagged_i,
    input  logic         tagged_valid_i,

    output logic         mem_wr_o,
    output addr_t        mem_addr_o,
    output payload_t     mem_data_o
);

    localparam addr_t BASE_BYTES = addr_t'(BASE_ADDR_4KB) * addr_t'(4096);

    addr_t slot_part;
    addr_t ident_part;
    addr_t word_part;
    addr_t wr_addr;

    // slot and ident select a region, the offset picks the 8-byte word in it
    assign slot_part  = addr_t'(tagged_i.slot) * addr_t'(SLOT_BYTES);
    assign ident_part = addr_t'(tagged_i.ident) * addr_t'(IDENT_BYTES);
    assign word_part  = addr_t'(tagged_i.offset) << 3;
    assign wr_addr    = BASE_BYTES + slot_part + ident_part + word_part;

    always_ff @(posedge memclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_wr_o <= 1'b0;
        end else begin
            mem_wr_o <= tagged_valid_i;
        end
    end

    // address and data only matter while mem_wr_o is high
    always_ff @(posedge memclk) begin
        if (tagged_valid_i) begin
            mem_addr_o <= wr_addr;
            mem_data_o <= tagged_i.payload;
        end
    end

endmodule

// ==== completion_gen.sv ====
`timescale 1ns/1ps

module completion_gen import evbuf_pkg::*; (
    input  logic         memclk,
    input  logic         rst_n_i,

    input  tagged_word_t tagged_i,
    input  logic         tagged_valid_i,

    output cmpl_t        cmpl_o,
    output logic         cmpl_valid_o
);

    // words of the open event seen so far
    wcount_t count_q;
    wcount_t count_next;

    logic    close_ev;

    assign count_next = count_q + 1'b1;
    assign close_ev   = tagged_valid_i && tagged_i.ev_end;

    always_ff @(posedge memclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (tagged_valid_i) begin
            if (tagged_i.ev_end) begin
                count_q <= '0;
            end else begin
                count_q <= count_next;
            end
        end
    end

    always_ff @(posedge memclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cmpl_valid_o <= 1'b0;
        end else begin
            // lines up with the final word's memory write
            cmpl_valid_o <= close_ev;
        end
    end

    // total includes the closing word
    always_ff @(posedge memclk) begin
        if (close_ev) begin
            cmpl_o.slot   <= tagged_i.slot;
            cmpl_o.wcount <= count_next;
        end
    end

endmodule

// ==== turfio_event_writer.sv ====
`timescale 1ns/1ps

module turfio_event_writer import evbuf_pkg::*; #(
    parameter int unsigned BASE_ADDR_4KB = 4
) (
    input  logic     memclk,
    input  logic     rst_n_i,

    // payload stream from the event accumulator
    input  payload_t payload_i,
    input  logic     payload_valid_i,
    input  logic     payload_last_i,
    input  ident_t   payload_ident_i,
    output logic     payload_has_space_o,
    output logic     overflow_o,

    // slot release from software
    input  logic     done_valid_i,
    input  slot_t    done_slot_i,

    // memory write port
    output logic     mem_wr_o,
    output addr_t    mem_addr_o,
    output payload_t mem_data_o,

    // event completion
    output cmpl_t    cmpl_o,
    output logic     cmpl_valid_o
);

    tagged_word_t tagged_w;
    logic         tagged_valid_w;

    // decode: slot pool and word tagging
    payload_decode u_decode (
        .memclk              (memclk),
        .rst_n_i             (rst_n_i),
        .payload_i           (payload_i),
        .payload_valid_i     (payload_valid_i),
        .payload_last_i      (payload_last_i),
        .payload_ident_i     (payload_ident_i),
        .payload_has_space_o (payload_has_space_o),
        .overflow_o          (overflow_o),
        .done_valid_i        (done_valid_i),
        .done_slot_i         (done_slot_i),
        .tagged_o            (tagged_w),
        .tagged_valid_o      (tagged_valid_w)
    );

    // execute: one write per tagged word
    write_addr_gen #(
        .BASE_ADDR_4KB (BASE_ADDR_4KB)
    ) u_addr_gen (
        .memclk         (memclk),
        .rst_n_i        (rst_n_i),
        .tagged_i       (tagged_w),
        .tagged_valid_i (tagged_valid_w),
        .mem_wr_o       (mem_wr_o),
        .mem_addr_o     (mem_addr_o),
        .mem_data_o     (mem_data_o)
    );

    // result: word count and completion record
    completion_gen u_cmpl_gen (
        .memclk         (memclk),
        .rst_n_i        (rst_n_i),
        .tagged_i       (tagged_w),
        .tagged_valid_i (tagged_valid_w),
        .cmpl_o         (cmpl_o),
        .cmpl_valid_o   (cmpl_valid_o)
    );

endmodule

// ==== turfio_event_writer_tb.sv ====
`timescale 1ns/1ps

module turfio_event_writer_tb import evbuf_pkg::*; ();

    localparam int unsigned BASE_4KB = 32;
    localparam int MEM_DEPTH = 256;

    typedef struct packed {
        addr_t    addr;
        payload_t data;
        int       take;
    } exp_wr_t;

    typedef struct packed {
        cmpl_t rec;
        int    take;
    } exp_cmpl_t;

    logic     memclk;
    logic     rst_n_i;
    payload_t payload_i;
    logic     payload_valid_i;
    logic     payload_last_i;
    ident_t   payload_ident_i;
    logic     done_valid_i;
    slot_t    done_slot_i;
    logic     payload_has_space_o;
    logic     overflow_o;
    logic     mem_wr_o;
    addr_t    mem_addr_o;
    payload_t mem_data_o;
    cmpl_t    cmpl_o;
    logic     cmpl_valid_o;

    logic [31:0] cmd_mem [MEM_DEPTH];
    integer      seed;
    int          cyc;
    int          limit;
    int          err_cnt;
    int          test_words;
    int          ovf_expected;
    int          ovf_seen;

    // reference model of the pool and the open event
    exp_wr_t     wr_q [$];
    exp_cmpl_t   cmpl_q [$];
    slot_t       pool_q [$];
    logic        ev_open;
    slot_t       cur_slot;
    int          offset;
    int          ev_words;

    initial memclk = 1'b0;
    always #50 memclk = ~memclk;

    turfio_event_writer #(
        .BASE_ADDR_4KB (BASE_4KB)
    ) dut_i (
        .memclk              (memclk),
        .rst_n_i             (rst_n_i),
        .payload_i           (payload_i),
        .payload_valid_i     (payload_valid_i),
        .payload_last_i      (payload_last_i),
        .payload_ident_i     (payload_ident_i),
        .payload_has_space_o (payload_has_space_o),
        .overflow_o          (overflow_o),
        .done_valid_i        (done_valid_i),
        .done_slot_i         (done_slot_i),
        .mem_wr_o            (mem_wr_o),
        .mem_addr_o          (mem_addr_o),
        .mem_data_o          (mem_data_o),
        .cmpl_o              (cmpl_o),
        .cmpl_valid_o        (cmpl_valid_o)
    );

    // byte address from base, slot, ident and word offset
    function automatic addr_t expected_addr(input slot_t slot, input ident_t id, input int offs);
        return addr_t'(int'(BASE_4KB) * 4096 + int'(slot) * 131072 + int'(id) * 16384
                       + offs * 8);
    endfunction

    // rough run length in cycles, used for the timeout
    function automatic int cycles_in_file();
        int          total;
        logic [31:0] cmd;
        total = 5;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            cmd = cmd_mem[i];
            case (cmd[31:28])
                4'h1:    total += int'(cmd[15:0]) + int'(cmd[27:24]);
                4'h2:    total += int'(cmd[15:0]);
                4'h3:    total += 1;
                4'h4:    total += 2;
                4'h5:    total += 1;
                4'hf:    total += 4;
                default: total += 0;
            endcase
        end
        return total;
    endfunction

    // monitor, outputs seen here were registered on the previous edge
    always @(posedge memclk) begin
        exp_wr_t   ew;
        exp_cmpl_t ec;
        if (rst_n_i) begin
            if (mem_wr_o) begin
                if (wr_q.size() == 0) begin
                    $display("unexpected memory write at %0t to address %h", $time, mem_addr_o);
                    err_cnt++;
                end else begin
                    ew = wr_q.pop_front();
                    if (mem_addr_o !== ew.addr) begin
                        $display("ERROR at %0t: mem_addr_o expected %h got %h",
                                 $time, ew.addr, mem_addr_o);
                        err_cnt++;
                    end
                    if (mem_data_o !== ew.data) begin
                        $display("ERROR at %0t: mem_data_o expected %h got %h",
                                 $time, ew.data, mem_data_o);
                        err_cnt++;
                    end
                    if (cyc != ew.take + 2) begin
                        $display("ERROR at %0t: mem_wr_o expected at edge %0d got edge %0d",
                                 $time, ew.take + 2, cyc);
                        err_cnt++;
                    end
                end
            end
            if (cmpl_valid_o) begin
                if (cmpl_q.size() == 0) begin
                    $display("unexpected completion at %0t for slot %0d", $time, cmpl_o.slot);
                    err_cnt++;
                end else begin
                    ec = cmpl_q.pop_front();
                    if (cmpl_o !== ec.rec) begin
                        $display("ERROR at %0t: cmpl_o expected %h got %h",
                                 $time, ec.rec, cmpl_o);
                        err_cnt++;
                    end
                    if (cyc != ec.take + 2) begin
                        $display("ERROR at %0t: cmpl_valid_o expected at edge %0d got edge %0d",
                                 $time, ec.take + 2, cyc);
                        err_cnt++;
                    end
                end
            end
            if (overflow_o) begin
                ovf_seen++;
            end
        end
        cyc = cyc + 1;
        if (limit > 0 && cyc >= limit) begin
            $display("timeout: the run passed its limit of %0d cycles", limit);
            $display("Errors found");
            $finish;
        end
    end

    task automatic drive_idle();
        @(negedge memclk);
        payload_valid_i = 1'b0;
        payload_last_i  = 1'b0;
        done_valid_i    = 1'b0;
    endtask

    // one word on the stream, the model decides whether it is taken
    task automatic send_word(input ident_t id, input logic last, output logic acc);
        exp_wr_t   ew;
        exp_cmpl_t ec;
        @(negedge memclk);
        payload_i       = {$random(seed), $random(seed)};
        payload_valid_i = 1'b1;
        payload_last_i  = last;
        payload_ident_i = id;
        done_valid_i    = 1'b0;
        acc = ev_open || (pool_q.size() != 0);
        if (!acc) begin
            ovf_expected++;
        end else begin
            if (!ev_open) begin
                cur_slot = pool_q.pop_front();
                ev_open  = 1'b1;
                ev_words = 0;
            end
            ew.addr = expected_addr(cur_slot, id, offset);
            ew.data = payload_i;
            ew.take = cyc;
            wr_q.push_back(ew);
            ev_words++;
            test_words++;
            if (last && id == ident_t'(LAST_IDENT)) begin
                ec.rec.slot   = cur_slot;
                ec.rec.wcount = wcount_t'(ev_words);
                ec.take       = cyc;
                cmpl_q.push_back(ec);
                ev_open = 1'b0;
            end
            offset = last ? 0 : offset + 1;
        end
    endtask

    // gap cycles of idle go in the middle of the chunk
    task automatic send_chunk(input ident_t id, input int len, input int gap);
        logic acc;
        for (int w = 0; w < len; w++) begin
            if (gap != 0 && w == len / 2) begin
                repeat (gap) drive_idle();
            end
            send_word(id, w == len - 1, acc);
        end
    endtask

    task automatic release_slot(input slot_t slot);
        @(negedge memclk);
        payload_valid_i = 1'b0;
        payload_last_i  = 1'b0;
        done_valid_i    = 1'b1;
        done_slot_i     = slot;
        pool_q.push_back(slot);
    endtask

    task automatic probe_overflow();
        logic acc;
        send_word(ident_t'(0), 1'b0, acc);
        drive_idle();
        if (acc) begin
            $display("overflow probe at %0t went out while a slot was still free", $time);
            err_cnt++;
        end else if (overflow_o !== 1'b1) begin
            $display("ERROR at %0t: overflow_o expected 1 got %b", $time, overflow_o);
            err_cnt++;
        end
    endtask

    task automatic check_space(input logic expv);
        drive_idle();
        if (payload_has_space_o !== expv) begin
            $display("ERROR at %0t: payload_has_space_o expected %b got %b",
                     $time, expv, payload_has_space_o);
            err_cnt++;
        end
    endtask

    initial begin
        int          pc;
        int          test_no;
        int          tests_failed;
        int          err_base;
        logic [31:0] cmd;
        logic        at_end;
        seed            = 32'hcc587dbc;
        rst_n_i         = 1'b0;
        payload_i       = '0;
        payload_valid_i = 1'b0;
        payload_last_i  = 1'b0;
        payload_ident_i = '0;
        done_valid_i    = 1'b0;
        done_slot_i     = '0;
        cyc             = 0;
        err_cnt         = 0;
        ovf_expected    = 0;
        ovf_seen        = 0;
        ev_open         = 1'b0;
        cur_slot        = '0;
        offset          = 0;
        ev_words        = 0;
        test_words      = 0;
        test_no         = 0;
        tests_failed    = 0;
        err_base        = 0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            cmd_mem[i] = '0;
        end
        $readmemh("event_input.txt", cmd_mem);
        limit = cycles_in_file() + 200;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            pool_q.push_back(slot_t'(s));
        end

        repeat (5) @(negedge memclk);
        rst_n_i = 1'b1;

        pc     = 0;
        at_end = 1'b0;
        while (pc < MEM_DEPTH && !at_end) begin
            cmd = cmd_mem[pc];
            pc++;
            case (cmd[31:28])
                4'h1: send_chunk(ident_t'(cmd[20:16]), int'(cmd[15:0]), int'(cmd[27:24]));
                4'h2: repeat (int'(cmd[15:0])) drive_idle();
                4'h3: release_slot(slot_t'(cmd[1:0]));
                4'h4: probe_overflow();
                4'h5: check_space(cmd[0]);
                4'hf: begin
                    // let the words in flight reach the monitor
                    while (wr_q.size() != 0 || cmpl_q.size() != 0) begin
                        drive_idle();
                    end
                    test_no++;
                    if (err_cnt != err_base) begin
                        tests_failed++;
                    end
                    $display("test %0d finished: %0d words, %0d errors",
                             test_no, test_words, err_cnt - err_base);
                    err_base   = err_cnt;
                    test_words = 0;
                end
                default: at_end = 1'b1;
            endcase
        end

        repeat (4) drive_idle();
        if (ovf_seen != ovf_expected) begin
            $display("overflow_o pulsed %0d times for %0d dropped words", ovf_seen, ovf_expected);
            err_cnt++;
        end
        if (test_no == 0) begin
            $display("no test found in event_input.txt");
            err_cnt++;
        end
        $display("summary: %0d tests, %0d failed, %0d errors", test_no, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== event_input.txt ====
// columns: op[31:28] gap[27:24] ident[20:16] arg[15:0], one hex command per line
// op 1 chunk (arg words, gap idle mid-chunk) 2 idle 3 done slot 4 overflow 5 has_space f end 0 stop

// test 1: one event over idents 0 to 6 into slot 0
50000001
20000004
10000003
10010002
10020004
10030001
10040002
10050003
10060005
f0000000

// test 2: back to back events into slots 1, 2 and 3
10000002
10060003
10060001
10030004
10060002
50000000
f0000000

// test 3: pool empty, a word is dropped
50000000
40000000
50000000
f0000000

// test 4: slot 2 returns and takes the next event
30000002
50000001
10010003
10060002
50000000
f0000000

// test 5: idle gaps inside chunks, slots 0 then 3
30000000
30000003
13020006
12060004
11060005
50000000
f0000000

// test 6: a longer chunk into slot 1
30000001
30000002
10050028
10060001
50000001
f0000000

00000000

// ==== verilog.f ====
evbuf_pkg.sv
payload_decode.sv
write_addr_gen.sv
completion_gen.sv
turfio_event_writer.sv
turfio_event_writer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the event writer testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --top-module turfio_event_writer_tb -f verilog.f \
    && ./obj_dir/Vturfio_event_writer_tb > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat "$LOG"
grep -q "Errors found" "$LOG" \
    && { echo "FAIL"; exit 1; } \
    || { echo "PASS"; exit 0; }
